// ==== Makefile ====
TOP = memSubsystemTb

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): all.f $(wildcard logic/*.sv) $(wildcard tb/*.sv)
	verilator --binary --timing -Wno-fatal -f all.f --top-module $(TOP) -o V$(TOP)

lint:
	verilator --lint-only -Wall --top-module memSubsystem \
		logic/memPkg.sv logic/byteRam.sv logic/memCtrl.sv \
		logic/instFetch.sv logic/memSubsystem.sv

clean:
	rm -rf obj_dir

// ==== all.f ====
logic/memPkg.sv
logic/byteRam.sv
logic/memCtrl.sv
logic/instFetch.sv
logic/memSubsystem.sv
tb/memSubsystemTb.sv

// ==== logic/byteRam.sv ====
`timescale 1ns/100ps

module byteRam (
    input  logic                            clk,
    input  logic [memPkg::RamAddrWidth-1:0] ramAddr,
    input  logic                            ramWe,
    input  logic [7:0]                      ramWdata,
    output logic [7:0]                      ramRdata
);

    logic [7:0] mem [0:(2**memPkg::RamAddrWidth)-1];

    always_ff @(posedge clk) begin
        if (ramWe) begin
            mem[ramAddr] <= ramWdata;
        end
    end

    // registered read, data follows the address by one cycle
    always_ff @(posedge clk) begin
        ramRdata <= mem[ramAddr];
    end

endmodule

// ==== logic/instFetch.sv ====
`timescale 1ns/100ps

module instFetch (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         fetchEnable,
    input  logic                         redirect,
    input  logic [memPkg::AddrWidth-1:0] redirectPc,
    output logic                         fetchReq,
    output logic [memPkg::AddrWidth-1:0] fetchAddr,
    input  logic                         fetchDone,
    input  logic [memPkg::WordWidth-1:0] fetchInst,
    output logic                         instValid,
    output logic [memPkg::WordWidth-1:0] inst,
    output logic [memPkg::AddrWidth-1:0] instPc
);

    logic [memPkg::AddrWidth-1:0] pc;
    logic                         discard;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= memPkg::ResetPc;
            fetchReq <= 1'b0;
            discard <= 1'b0;
            instValid <= 1'b0;
        end else begin
            // a redirect in the done cycle also makes the result stale
            instValid <= fetchDone && !discard && !redirect;
            if (fetchDone) begin
                fetchReq <= 1'b0;
                discard <= 1'b0;
            end else if (!fetchReq && fetchEnable) begin
                fetchReq <= 1'b1;
            end
            if (redirect) begin
                pc <= redirectPc;
                if (fetchReq && !fetchDone) begin
                    discard <= 1'b1;
                end
            end else if (fetchDone && !discard) begin
                pc <= pc + 'd4;
            end
        end
    end

    // address frozen while the request is up
    always_ff @(posedge clk) begin
        if (!fetchReq) begin
            fetchAddr <= redirect ? redirectPc : pc;
        end
        if (fetchDone) begin
            inst <= fetchInst;
            instPc <= fetchAddr;
        end
    end

endmodule

// ==== logic/memCtrl.sv ====
`timescale 1ns/100ps

module memCtrl (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            rdy,
    input  logic                            ioBufferFull,

    input  logic                            fetchReq,
    input  logic [memPkg::AddrWidth-1:0]    fetchAddr,
    output logic                            fetchDone,
    output logic [memPkg::WordWidth-1:0]    fetchInst,

    input  logic                            dataReq,
    input  logic                            dataStore,
    input  logic [memPkg::LenWidth-1:0]     dataLen,
    input  logic [memPkg::AddrWidth-1:0]    dataAddr,
    input  logic [memPkg::WordWidth-1:0]    dataWdata,
    output logic                            dataDone,
    output logic [memPkg::WordWidth-1:0]    dataRdata,

    output logic [memPkg::RamAddrWidth-1:0] ramAddr,
    output logic                            ramWe,
    output logic [7:0]                      ramWdata,
    input  logic [7:0]                      ramRdata,

    output logic                            ioValid,
    output logic [7:0]                      ioByte
);

    logic [1:0]                      state;
    logic [memPkg::LenWidth-1:0]     stage;
    logic [memPkg::LenWidth-1:0]     lenReg;
    logic [memPkg::AddrWidth-1:0]    baseAddr;
    logic [memPkg::WordWidth-1:0]    wdataReg;
    logic [memPkg::WordWidth-1:0]    asmWord;
    logic [memPkg::WordWidth-1:0]    loadWord;
    logic [memPkg::RamAddrWidth-1:0] offset;
    logic                            ioStore;
    logic                            dataIoHit;
    logic                            dataBlocked;
    logic                            loading;
    logic                            lastStage;

    assign dataIoHit = (dataAddr & memPkg::IoBase) == memPkg::IoBase;

    // I/O store waits for room in the external buffer
    assign dataBlocked = dataStore && dataIoHit && ioBufferFull;

    assign loading = (state == memPkg::StFetch) || (state == memPkg::StLoad);

    // loads end one stage later, the last byte is still coming back from RAM
    always_comb begin
        if (loading) begin
            lastStage = (stage == lenReg);
        end else begin
            lastStage = (stage == lenReg - 1'b1);
        end
    end

    always_comb begin
        if (rdy) begin
            offset = {{(memPkg::RamAddrWidth - memPkg::LenWidth){1'b0}}, stage};
        end else begin
            // paused: keep reading the byte the next collect expects
            offset = {{(memPkg::RamAddrWidth - memPkg::LenWidth){1'b0}}, stage} - 1'b1;
        end
    end

    assign ramAddr = baseAddr[memPkg::RamAddrWidth-1:0] + offset;

    assign ramWdata = wdataReg[{stage[1:0], 3'b000} +: 8];
    assign ioByte = ramWdata;

    assign ramWe = rdy && (state == memPkg::StStore) && !ioStore;
    assign ioValid = rdy && (state == memPkg::StStore) && ioStore;

    // little endian, last byte straight from RAM, short loads zero-extended
    always_comb begin
        case (lenReg)
            memPkg::LenByte: loadWord = {24'b0, ramRdata};
            memPkg::LenHalf: loadWord = {16'b0, ramRdata, asmWord[7:0]};
            default:         loadWord = {ramRdata, asmWord[23:0]};
        endcase
    end

    assign fetchInst = loadWord;
    assign dataRdata = loadWord;

    assign fetchDone = rdy && (state == memPkg::StFetch) && lastStage;
    assign dataDone = rdy && lastStage
        && ((state == memPkg::StLoad) || (state == memPkg::StStore));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= memPkg::StIdle;
            stage <= '0;
        end else if (rdy) begin
            if (state == memPkg::StIdle) begin
                stage <= '0;
                // data port wins over fetch
                if (dataReq) begin
                    if (!dataBlocked) begin
                        state <= dataStore ? memPkg::StStore : memPkg::StLoad;
                    end
                end else if (fetchReq) begin
                    state <= memPkg::StFetch;
                end
            end else if (lastStage) begin
                state <= memPkg::StIdle;
            end else begin
                stage <= stage + 1'b1;
            end
        end
    end

    // request latch, only while idle
    always_ff @(posedge clk) begin
        if (rdy && state == memPkg::StIdle) begin
            if (dataReq) begin
                baseAddr <= dataAddr;
                lenReg <= dataLen;
                wdataReg <= dataWdata;
                ioStore <= dataStore && dataIoHit;
            end else begin
                baseAddr <= fetchAddr;
                lenReg <= memPkg::LenWord;
                ioStore <= 1'b0;
            end
        end
    end

    // byte returned in stage s belongs at offset s-1
    always_ff @(posedge clk) begin
        if (rdy && loading && stage != '0 && !lastStage) begin
            asmWord[{stage[1:0] - 2'd1, 3'b000} +: 8] <= ramRdata;
        end
    end

endmodule

// ==== logic/memPkg.sv ====
package memPkg;

    // bus widths
    localparam int AddrWidth = 32;
    localparam int WordWidth = 32;
    localparam int LenWidth = 3;

    // 4 KiB of RAM, addresses wrap
    localparam int RamAddrWidth = 12;

    // access length is the number of bytes moved
    localparam logic [LenWidth-1:0] LenByte = 3'd1;
    localparam logic [LenWidth-1:0] LenHalf = 3'd2;
    localparam logic [LenWidth-1:0] LenWord = 3'd4;

    // address is I/O when bits 17 and 16 are both set
    localparam logic [AddrWidth-1:0] IoBase = 32'h0003_0000;

    localparam logic [AddrWidth-1:0] ResetPc = 32'h0000_0000;

    // controller states
    localparam logic [1:0] StIdle = 2'd0;
    localparam logic [1:0] StFetch = 2'd1;
    localparam logic [1:0] StLoad = 2'd2;
    localparam logic [1:0] StStore = 2'd3;

endpackage

// ==== logic/memSubsystem.sv ====
`timescale 1ns/100ps

module memSubsystem (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rdy,
    input  logic                         ioBufferFull,
    input  logic                         fetchEnable,
    input  logic                         redirect,
    input  logic [memPkg::AddrWidth-1:0] redirectPc,
    output logic                         instValid,
    output logic [memPkg::WordWidth-1:0] inst,
    output logic [memPkg::AddrWidth-1:0] instPc,
    input  logic                         dataReq,
    input  logic                         dataStore,
    input  logic [memPkg::LenWidth-1:0]  dataLen,
    input  logic [memPkg::AddrWidth-1:0] dataAddr,
    input  logic [memPkg::WordWidth-1:0] dataWdata,
    output logic                         dataDone,
    output logic [memPkg::WordWidth-1:0] dataRdata,
    output logic                         ioValid,
    output logic [7:0]                   ioByte
);

    logic                            fetchReq;
    logic [memPkg::AddrWidth-1:0]    fetchAddr;
    logic                            fetchDone;
    logic [memPkg::WordWidth-1:0]    fetchInst;
    logic [memPkg::RamAddrWidth-1:0] ramAddr;
    logic                            ramWe;
    logic [7:0]                      ramWdata;
    logic [7:0]                      ramRdata;

    instFetch u_instFetch (
        .clk(clk), .rst(rst), .fetchEnable(fetchEnable),
        .redirect(redirect), .redirectPc(redirectPc),
        .fetchReq(fetchReq), .fetchAddr(fetchAddr),
        .fetchDone(fetchDone), .fetchInst(fetchInst),
        .instValid(instValid), .inst(inst), .instPc(instPc)
    );

    memCtrl u_memCtrl (
        .clk(clk), .rst(rst), .rdy(rdy), .ioBufferFull(ioBufferFull),
        .fetchReq(fetchReq), .fetchAddr(fetchAddr),
        .fetchDone(fetchDone), .fetchInst(fetchInst),
        .dataReq(dataReq), .dataStore(dataStore), .dataLen(dataLen),
        .dataAddr(dataAddr), .dataWdata(dataWdata),
        .dataDone(dataDone), .dataRdata(dataRdata),
        .ramAddr(ramAddr), .ramWe(ramWe), .ramWdata(ramWdata), .ramRdata(ramRdata),
        .ioValid(ioValid), .ioByte(ioByte)
    );

    byteRam u_byteRam (
        .clk(clk), .ramAddr(ramAddr), .ramWe(ramWe),
        .ramWdata(ramWdata), .ramRdata(ramRdata)
    );

endmodule

// ==== tb/memSubsystemTb.sv ====
`timescale 1ns/100ps

module memSubsystemTb;

    logic                         clk = 1'b0;
    logic                         rst;
    logic                         rdy;
    logic                         ioBufferFull;
    logic                         fetchEnable;
    logic                         redirect;
    logic [memPkg::AddrWidth-1:0] redirectPc;
    logic                         instValid;
    logic [memPkg::WordWidth-1:0] inst;
    logic [memPkg::AddrWidth-1:0] instPc;
    logic                         dataReq;
    logic                         dataStore;
    logic [memPkg::LenWidth-1:0]  dataLen;
    logic [memPkg::AddrWidth-1:0] dataAddr;
    logic [memPkg::WordWidth-1:0] dataWdata;
    logic                         dataDone;
    logic [memPkg::WordWidth-1:0] dataRdata;
    logic                         ioValid;
    logic [7:0]                   ioByte;

    // reference copy of the byte RAM
    logic [7:0] model [0:4095];
    integer     seed = 29949;
    logic       randomPause = 1'b0;
    logic       limitReady = 1'b0;
    int         lineCount = 0;

    memSubsystem u_memSubsystem (
        .clk(clk), .rst(rst), .rdy(rdy), .ioBufferFull(ioBufferFull),
        .fetchEnable(fetchEnable), .redirect(redirect), .redirectPc(redirectPc),
        .instValid(instValid), .inst(inst), .instPc(instPc),
        .dataReq(dataReq), .dataStore(dataStore), .dataLen(dataLen),
        .dataAddr(dataAddr), .dataWdata(dataWdata),
        .dataDone(dataDone), .dataRdata(dataRdata),
        .ioValid(ioValid), .ioByte(ioByte)
    );

    always #10 clk = ~clk;

    // drop rdy on about a quarter of the cycles
    always @(posedge clk) begin
        if (rst || !randomPause) begin
            rdy <= 1'b1;
        end else begin
            rdy <= ($random(seed) & 3) != 0;
        end
    end

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string msg);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
            $display("test failed");
            $fatal(1, "value check");
        end
    endtask

    function automatic logic [31:0] modelWord(input logic [31:0] addr, input logic [2:0] len);
        logic [31:0] w;
        logic [11:0] a;
        w = '0;
        for (int k = 0; k < int'(len); k++) begin
            a = addr[11:0] + 12'(k);
            w[k*8 +: 8] = model[a];
        end
        return w;
    endfunction

    task automatic dataAccess(input logic store, input logic [31:0] addr, input logic [2:0] len,
                              input logic [31:0] wdata, input int hold, input logic timed);
        int          cycles;
        int          ioCount;
        logic        isIo;
        logic [11:0] a;
        logic [31:0] expected;
        isIo = store && addr[17] && addr[16];
        expected = modelWord(addr, len);
        cycles = 0;
        ioCount = 0;
        @(posedge clk);
        dataReq <= 1'b1;
        dataStore <= store;
        dataLen <= len;
        dataAddr <= addr;
        dataWdata <= wdata;
        ioBufferFull <= (hold > 0);
        repeat (hold) begin
            @(negedge clk);
            checkValue(32'(ioValid), 32'd0, "ioValid while buffer full");
        end
        if (hold > 0) begin
            @(posedge clk);
            ioBufferFull <= 1'b0;
        end
        do begin
            @(negedge clk);
            cycles++;
            if (ioValid) begin
                checkValue(32'(isIo), 32'd1, "ioValid on a RAM access");
                checkValue(32'(ioByte), 32'(wdata[ioCount*8 +: 8]), "ioByte");
                ioCount++;
            end
        end while (!dataDone);
        // negedge count includes the cycle before acceptance
        if (timed && !randomPause && hold == 0) begin
            checkValue(cycles, int'(len) + (store ? 1 : 2), "data latency");
        end
        if (store && isIo) begin
            checkValue(ioCount, int'(len), "I/O byte count");
        end else if (store) begin
            for (int k = 0; k < int'(len); k++) begin
                a = addr[11:0] + 12'(k);
                model[a] = wdata[k*8 +: 8];
            end
        end else begin
            checkValue(dataRdata, expected, "load data");
        end
        @(posedge clk);
        dataReq <= 1'b0;
    endtask

    // stop fetching and let the last fetch come back
    task automatic drainFetch();
        @(posedge clk);
        fetchEnable <= 1'b0;
        do @(negedge clk); while (u_memSubsystem.fetchReq);
        @(negedge clk);
    endtask

    task automatic runFetch(input logic [31:0] pc, input int count);
        int got;
        got = 0;
        @(posedge clk);
        redirect <= 1'b1;
        redirectPc <= pc;
        @(posedge clk);
        redirect <= 1'b0;
        fetchEnable <= 1'b1;
        fork
            while (got < count) begin
                @(negedge clk);
                if (instValid) begin
                    checkValue(instPc, pc + 32'(4 * got), "instPc");
                    checkValue(inst, modelWord(pc + 32'(4 * got), 3'd4), "inst");
                    got++;
                end
            end
            begin
                repeat (6) @(posedge clk);
                dataAccess(1'b0, pc + 32'h40, 3'd4, 32'h0, 0, 1'b0);
            end
        join
        drainFetch();
    endtask

    task automatic redirectInFlight(input logic [31:0] pc);
        @(posedge clk);
        fetchEnable <= 1'b1;
        do @(negedge clk); while (!u_memSubsystem.fetchReq);
        @(posedge clk);
        redirect <= 1'b1;
        redirectPc <= pc;
        @(posedge clk);
        redirect <= 1'b0;
        do @(negedge clk); while (!instValid);
        checkValue(instPc, pc, "instPc after redirect");
        checkValue(inst, modelWord(pc, 3'd4), "inst after redirect");
        drainFetch();
    endtask

    initial begin
        wait (limitReady);
        #(lineCount * 200 * 20);
        $display("run timed out after %0d command lines", lineCount);
        $display("test failed");
        $fatal(1, "watchdog");
    end

    initial begin
        int          fd;
        string       line;
        logic [7:0]  cmd;
        logic [31:0] a0;
        logic [31:0] a1;
        logic [31:0] a2;
        logic [31:0] a3;
        rst = 1'b1;
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        fetchEnable = 1'b0;
        redirect = 1'b0;
        redirectPc = '0;
        dataReq = 1'b0;
        dataStore = 1'b0;
        dataLen = '0;
        dataAddr = '0;
        dataWdata = '0;
        for (int i = 0; i < 4096; i++) begin
            model[i] = 8'((i * 37) + ((i >> 8) * 11));
            u_memSubsystem.u_byteRam.mem[i] = model[i];
        end
        fd = $fopen("tb/memTests.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/memTests.txt");
            $display("test failed");
            $fatal(1, "missing stimulus");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin
                lineCount++;
            end
        end
        $fclose(fd);
        limitReady = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        fd = $fopen("tb/memTests.txt", "r");
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin
                void'($sscanf(line, "%c %h %h %h %h", cmd, a0, a1, a2, a3));
                case (cmd)
                    "S": dataAccess(1'b1, a0, a1[2:0], a2, 0, 1'b1);
                    "L": begin
                        checkValue(modelWord(a0, a1[2:0]), a2, "expected value in file");
                        dataAccess(1'b0, a0, a1[2:0], 32'h0, 0, 1'b1);
                    end
                    "F": runFetch(a0, int'(a1));
                    "R": redirectInFlight(a0);
                    "I": dataAccess(1'b1, a0, a1[2:0], a2, int'(a3), 1'b1);
                    "P": begin
                        randomPause <= a0[0];
                        repeat (2) @(posedge clk);
                    end
                    default: begin
                        $display("unknown command in test file: %s", line);
                        $display("test failed");
                        $fatal(1, "bad command");
                    end
                endcase
            end
        end
        $fclose(fd);
        $display("test passed");
        $finish;
    end

endmodule

// ==== tb/memTests.txt ====
# cmd addr len data-or-expected hold, all hex
# S store, L load, F fetch pc count, R redirect pc, I io store, P random rdy 0/1
P 0
S 00000100 4 11223344
L 00000100 4 11223344
S 00000102 1 aa
L 00000100 4 11aa3344
S 00000104 2 beef
L 00000104 2 0000beef
L 00000101 2 0000aa33
L 00000105 1 000000be
P 1
S 00000200 4 deadbeef
L 00000200 4 deadbeef
S 00000010 4 cafef00d
I 00030010 4 01020304 5
L 00030010 4 cafef00d
I 00030020 2 0000a5c3 0
F 00000100 4
F 00000040 6
R 00000200
S 00000fff 1 7e
L 00000fff 1 0000007e
P 0
L 00000010 4 cafef00d
